/* sdram_mcb_defines.svh */
`ifndef SDRAM_MCB_DEFINES_SVH
`define SDRAM_MCB_DEFINES_SVH

// word address is {bank[1:0], row[12:0], col[8:0]}
`define SDRAM_MCB_ADDR_W 24

`define SDRAM_MCB_COL_W 9 // column bits inside a row

`define SDRAM_MCB_ROW_WORDS 512 // words per row, a stage never crosses it

`define SDRAM_MCB_LEN_W 24 // transfer length in words

`define SDRAM_MCB_DATA_W 16 // sdram word

`define SDRAM_MCB_FIFO_DEPTH 1024 // entries in each fifo

`define SDRAM_MCB_CNT_W 10 // fifo count and stage count width

// almost full margin below depth, wr_rdy drops above depth - margin
`define SDRAM_MCB_AF_MARGIN 16

`define SDRAM_MCB_REQ_W 60 // packed memory request width

`define SDRAM_MCB_ACK_W 18 // packed memory response width

`define SDRAM_MCB_STAT_W 13 // packed tracker status width

`endif

/* sdram_mcb_pkg.sv */
`include "sdram_mcb_defines.svh"

package sdram_mcb_pkg;

  typedef logic [`SDRAM_MCB_DATA_W-1:0] word_t; // one sdram word
  typedef logic [`SDRAM_MCB_ADDR_W-1:0] addr_t; // {bank, row, col}
  typedef logic [`SDRAM_MCB_LEN_W-1:0] len_t; // length in words, nonzero
  typedef logic [`SDRAM_MCB_CNT_W-1:0] stage_cnt_t; // fifo fill or stage count

  // request towards the memory, level held until the first ack
  typedef struct packed {
    logic                    wr_req; // write burst wanted
    logic                    rd_req; // read burst wanted
    addr_t                   addr; // first word of the stage
    logic [`SDRAM_MCB_CNT_W:0] len; // stage words, 1..512
    logic [`SDRAM_MCB_REQ_W-`SDRAM_MCB_ADDR_W-`SDRAM_MCB_CNT_W-4:0] spare; // tied low
  } mem_req_t;

  // one ack per word, either direction
  typedef struct packed {
    logic  wr_ack; // memory takes mem_wdata this edge
    logic  rd_ack; // rd_data valid this edge
    word_t rd_data; // word read back
  } mem_ack_t;

  // tracker view for the scheduler
  typedef struct packed {
    logic                    pending; // transfer accepted, not finished
    logic                    last; // current stage ends the transfer
    logic [`SDRAM_MCB_CNT_W:0] stage_len; // words in the current stage
  } xfer_stat_t;

  typedef enum logic [2:0] {
    idle          = 3'd0, // waiting for an eligible stage
    pre_wr        = 3'd1, // one cycle set up, request rises after it
    writing       = 3'd2, // wr acks flowing
    wr_stage_cplt = 3'd3, // tracker advances, toggle flips
    pre_rd        = 3'd4,
    reading       = 3'd5, // rd acks flowing
    rd_stage_cplt = 3'd6
  } sched_state_t;

endpackage

/* sdram_mcb_fifo.sv */
`include "sdram_mcb_defines.svh"

// circular buffer, one slot stays free so count fits stage_cnt_t
module sdram_mcb_fifo #(
  parameter int DEPTH = `SDRAM_MCB_FIFO_DEPTH // power of two
) (
  input  logic                       clk_sdram,
  input  logic                       rst_n,
  input  logic                       push, // write strobe
  input  sdram_mcb_pkg::word_t       push_data,
  input  logic                       pop, // read strobe, head leaves
  output sdram_mcb_pkg::word_t       pop_data, // head word, combinational
  output sdram_mcb_pkg::stage_cnt_t  count, // words held
  output logic                       empty,
  output logic                       almost_full // within margin of depth
);

  localparam int PTR_W = $clog2(DEPTH);

  sdram_mcb_pkg::word_t mem [DEPTH]; // storage, no reset
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic                 full;
  logic                 do_push;
  logic                 do_pop;

  assign full        = (count == sdram_mcb_pkg::stage_cnt_t'(DEPTH - 1)); // depth-1 usable
  assign empty       = (count == '0);
  assign almost_full = (count > sdram_mcb_pkg::stage_cnt_t'(DEPTH - `SDRAM_MCB_AF_MARGIN));
  assign do_push     = push & ~full; // push on full dropped
  assign do_pop      = pop & ~empty; // pop on empty dropped
  assign pop_data    = mem[rd_ptr]; // show-ahead head

  always_ff @(posedge clk_sdram) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // natural wrap
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1; // fill only
        2'b01: count <= count - 1'b1; // drain only
        default: count <= count; // both or neither
      endcase
    end
  end

endmodule

/* sdram_mcb_xfer.sv */
`include "sdram_mcb_defines.svh"

// one direction of transfer bookkeeping, load edge to last stage
module sdram_mcb_xfer (
  input  logic                      clk_sdram,
  input  logic                      rst_n,
  input  logic                      load, // level from the user
  input  sdram_mcb_pkg::addr_t      load_addr,
  input  sdram_mcb_pkg::len_t       load_len, // words, nonzero
  input  logic                      ack, // one per word moved
  input  logic                      stage_start, // clear word count
  input  logic                      stage_cplt, // advance address and length
  output sdram_mcb_pkg::xfer_stat_t stat,
  output sdram_mcb_pkg::addr_t      addr, // current stage start
  output logic                      stage_full // all stage words acked
);

  localparam int STAGE_W = `SDRAM_MCB_CNT_W + 1; // 512 must fit

  logic                 load_q; // input register
  logic                 load_qq; // previous level for edge
  sdram_mcb_pkg::addr_t addr_q;
  sdram_mcb_pkg::len_t  len_q;
  logic                 load_edge;
  logic                 pending;
  logic                 last;
  sdram_mcb_pkg::addr_t addr_r; // next word to move
  sdram_mcb_pkg::len_t  len_r; // words still to move
  logic [STAGE_W-1:0]   row_room; // words left in this row
  logic [STAGE_W-1:0]   stage_len;
  logic [STAGE_W-1:0]   ack_cnt; // acks in this stage

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      load_q  <= 1'b0;
      load_qq <= 1'b0;
    end else begin
      load_q  <= load;
      load_qq <= load_q;
    end
  end

  // sampled alongside load_q so the edge sees matching values
  always_ff @(posedge clk_sdram) begin
    addr_q <= load_addr;
    len_q  <= load_len;
  end

  assign load_edge = load_q & ~load_qq;
  assign row_room  = STAGE_W'(`SDRAM_MCB_ROW_WORDS) - STAGE_W'(addr_r[`SDRAM_MCB_COL_W-1:0]);
  assign stage_len = (len_r < sdram_mcb_pkg::len_t'(row_room)) ? STAGE_W'(len_r) : row_room;
  assign last      = (len_r == sdram_mcb_pkg::len_t'(stage_len)); // stage drains the rest

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      addr_r  <= '0;
      len_r   <= '0;
    end else if (load_edge && !pending) begin
      pending <= 1'b1; // edge while busy is lost
      addr_r  <= addr_q;
      len_r   <= len_q;
    end else if (stage_cplt) begin
      addr_r <= addr_r + sdram_mcb_pkg::addr_t'(stage_len); // may roll into next bank
      len_r  <= len_r - sdram_mcb_pkg::len_t'(stage_len);
      if (last) begin
        pending <= 1'b0; // same edge as the done pulse
      end
    end
  end

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      ack_cnt <= '0;
    end else if (stage_start) begin
      ack_cnt <= '0;
    end else if (ack) begin
      ack_cnt <= ack_cnt + 1'b1;
    end
  end

  assign stage_full = (ack_cnt == stage_len);
  assign addr       = addr_r;
  assign stat       = '{pending: pending, last: last, stage_len: stage_len};

endmodule

/* sdram_mcb_sched.sv */
`include "sdram_mcb_defines.svh"

// picks write or read stages, holds the memory request, signals done
module sdram_mcb_sched (
  input  logic                      clk_sdram,
  input  logic                      rst_n,
  input  sdram_mcb_pkg::xfer_stat_t wr_stat,
  input  sdram_mcb_pkg::xfer_stat_t rd_stat,
  input  sdram_mcb_pkg::stage_cnt_t wr_fifo_count, // words ready to write
  input  sdram_mcb_pkg::stage_cnt_t rd_fifo_count, // words awaiting the user
  input  logic                      wr_stage_full,
  input  logic                      rd_stage_full,
  input  sdram_mcb_pkg::mem_ack_t   mem_ack,
  input  sdram_mcb_pkg::addr_t      wr_addr_cur,
  input  sdram_mcb_pkg::addr_t      rd_addr_cur,
  output sdram_mcb_pkg::mem_req_t   mem_req,
  output logic                      wr_stage_start,
  output logic                      wr_stage_cplt,
  output logic                      rd_stage_start,
  output logic                      rd_stage_cplt,
  output logic                      wr_done, // one cycle per transfer
  output logic                      rd_done
);

  localparam int RD_LIMIT = `SDRAM_MCB_FIFO_DEPTH - 1; // read fill stays below this

  sdram_mcb_pkg::sched_state_t state;
  sdram_mcb_pkg::sched_state_t state_next;
  logic                        toggle; // 0 favours write, 1 favours read
  logic                        wr_ok; // write stage fully buffered
  logic                        rd_ok; // read stage fits the fifo
  logic [`SDRAM_MCB_CNT_W+1:0] rd_fill_sum; // fill after the stage lands
  logic                        req_wr;
  logic                        req_rd;
  sdram_mcb_pkg::addr_t        req_addr;
  logic [`SDRAM_MCB_CNT_W:0]   req_len;

  assign rd_fill_sum = {2'b00, rd_fifo_count} + {1'b0, rd_stat.stage_len};
  assign wr_ok       = wr_stat.pending && ({1'b0, wr_fifo_count} >= wr_stat.stage_len);
  assign rd_ok       = rd_stat.pending && (rd_fill_sum < RD_LIMIT);

  always_comb begin
    state_next = state;
    case (state)
      sdram_mcb_pkg::idle: begin
        if (!toggle) begin
          if (wr_ok) state_next = sdram_mcb_pkg::pre_wr;
          else if (rd_ok) state_next = sdram_mcb_pkg::pre_rd;
        end else begin
          if (rd_ok) state_next = sdram_mcb_pkg::pre_rd;
          else if (wr_ok) state_next = sdram_mcb_pkg::pre_wr;
        end
      end
      sdram_mcb_pkg::pre_wr: state_next = sdram_mcb_pkg::writing;
      sdram_mcb_pkg::writing: begin
        if (wr_stage_full) state_next = sdram_mcb_pkg::wr_stage_cplt; // last ack seen
      end
      sdram_mcb_pkg::wr_stage_cplt: state_next = sdram_mcb_pkg::idle;
      sdram_mcb_pkg::pre_rd: state_next = sdram_mcb_pkg::reading;
      sdram_mcb_pkg::reading: begin
        if (rd_stage_full) state_next = sdram_mcb_pkg::rd_stage_cplt;
      end
      sdram_mcb_pkg::rd_stage_cplt: state_next = sdram_mcb_pkg::idle;
      default: state_next = sdram_mcb_pkg::idle; // unused encoding
    endcase
  end

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      state   <= sdram_mcb_pkg::idle;
      toggle  <= 1'b0;
      req_wr  <= 1'b0;
      req_rd  <= 1'b0;
      wr_done <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      state   <= state_next;
      wr_done <= (state == sdram_mcb_pkg::wr_stage_cplt) && wr_stat.last;
      rd_done <= (state == sdram_mcb_pkg::rd_stage_cplt) && rd_stat.last;
      if (wr_stage_cplt || rd_stage_cplt) begin
        toggle <= ~toggle; // alternate after every stage
      end
      if (state == sdram_mcb_pkg::pre_wr) req_wr <= 1'b1;
      else if (mem_ack.wr_ack) req_wr <= 1'b0; // first ack drops the level
      if (state == sdram_mcb_pkg::pre_rd) req_rd <= 1'b1;
      else if (mem_ack.rd_ack) req_rd <= 1'b0;
    end
  end

  // stage address and length, valid while a request is up
  always_ff @(posedge clk_sdram) begin
    if (state == sdram_mcb_pkg::pre_wr) begin
      req_addr <= wr_addr_cur;
      req_len  <= wr_stat.stage_len;
    end else if (state == sdram_mcb_pkg::pre_rd) begin
      req_addr <= rd_addr_cur;
      req_len  <= rd_stat.stage_len;
    end
  end

  assign wr_stage_start = (state == sdram_mcb_pkg::pre_wr);
  assign rd_stage_start = (state == sdram_mcb_pkg::pre_rd);
  assign wr_stage_cplt  = (state == sdram_mcb_pkg::wr_stage_cplt);
  assign rd_stage_cplt  = (state == sdram_mcb_pkg::rd_stage_cplt);

  assign mem_req = '{
    wr_req: req_wr,
    rd_req: req_rd,
    addr:   req_addr,
    len:    req_len,
    spare:  '0
  };

endmodule

/* sdram_mcb_top.sv */
`include "sdram_mcb_defines.svh"

// user fifos and trackers around the stage scheduler
module sdram_mcb_top (
  input  logic                      clk_sdram,
  input  logic                      rst_n,
  input  logic                      wr_load, // rising edge starts a write
  input  sdram_mcb_pkg::addr_t      wr_addr,
  input  sdram_mcb_pkg::len_t       wr_length,
  input  logic                      wr_req, // din into write fifo
  input  sdram_mcb_pkg::word_t      din,
  output logic                      wr_rdy, // write fifo has room
  output logic                      wr_done,
  input  logic                      rd_load, // rising edge starts a read
  input  sdram_mcb_pkg::addr_t      rd_addr,
  input  sdram_mcb_pkg::len_t       rd_length,
  input  logic                      rd_req, // pop read fifo
  output sdram_mcb_pkg::word_t      dout, // head of read fifo
  output sdram_mcb_pkg::stage_cnt_t rd_fifo_cnt,
  output logic                      rd_fifo_empty,
  output logic                      rd_done,
  output sdram_mcb_pkg::mem_req_t   mem_req,
  input  sdram_mcb_pkg::mem_ack_t   mem_ack,
  output sdram_mcb_pkg::word_t      mem_wdata // popped on wr_ack
);

  sdram_mcb_pkg::stage_cnt_t  wr_fifo_count;
  logic                       wr_fifo_af;
  sdram_mcb_pkg::xfer_stat_t  wr_stat;
  sdram_mcb_pkg::xfer_stat_t  rd_stat;
  sdram_mcb_pkg::addr_t       wr_addr_cur;
  sdram_mcb_pkg::addr_t       rd_addr_cur;
  logic                       wr_stage_full;
  logic                       rd_stage_full;
  logic                       wr_stage_start;
  logic                       wr_stage_cplt;
  logic                       rd_stage_start;
  logic                       rd_stage_cplt;

  assign wr_rdy = ~wr_fifo_af;

  sdram_mcb_fifo #(.DEPTH(`SDRAM_MCB_FIFO_DEPTH)) u_wr_fifo (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .push       (wr_req),
    .push_data  (din),
    .pop        (mem_ack.wr_ack), // memory drains per word
    .pop_data   (mem_wdata),
    .count      (wr_fifo_count),
    .empty      (),
    .almost_full(wr_fifo_af)
  );

  sdram_mcb_fifo #(.DEPTH(`SDRAM_MCB_FIFO_DEPTH)) u_rd_fifo (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .push       (mem_ack.rd_ack), // memory fills per word
    .push_data  (mem_ack.rd_data),
    .pop        (rd_req),
    .pop_data   (dout),
    .count      (rd_fifo_cnt),
    .empty      (rd_fifo_empty),
    .almost_full()
  );

  sdram_mcb_xfer u_wr_xfer (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .load       (wr_load),
    .load_addr  (wr_addr),
    .load_len   (wr_length),
    .ack        (mem_ack.wr_ack),
    .stage_start(wr_stage_start),
    .stage_cplt (wr_stage_cplt),
    .stat       (wr_stat),
    .addr       (wr_addr_cur),
    .stage_full (wr_stage_full)
  );

  sdram_mcb_xfer u_rd_xfer (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .load       (rd_load),
    .load_addr  (rd_addr),
    .load_len   (rd_length),
    .ack        (mem_ack.rd_ack),
    .stage_start(rd_stage_start),
    .stage_cplt (rd_stage_cplt),
    .stat       (rd_stat),
    .addr       (rd_addr_cur),
    .stage_full (rd_stage_full)
  );

  sdram_mcb_sched u_sched (
    .clk_sdram     (clk_sdram),
    .rst_n         (rst_n),
    .wr_stat       (wr_stat),
    .rd_stat       (rd_stat),
    .wr_fifo_count (wr_fifo_count),
    .rd_fifo_count (rd_fifo_cnt),
    .wr_stage_full (wr_stage_full),
    .rd_stage_full (rd_stage_full),
    .mem_ack       (mem_ack),
    .wr_addr_cur   (wr_addr_cur),
    .rd_addr_cur   (rd_addr_cur),
    .mem_req       (mem_req),
    .wr_stage_start(wr_stage_start),
    .wr_stage_cplt (wr_stage_cplt),
    .rd_stage_start(rd_stage_start),
    .rd_stage_cplt (rd_stage_cplt),
    .wr_done       (wr_done),
    .rd_done       (rd_done)
  );

endmodule

/* sdram_mcb_tb_assertions.sv */
`include "sdram_mcb_defines.svh"

// protocol checks on the memory port, done pulses and fifo flags
module sdram_mcb_tb_assertions (
  input logic                      clk_sdram,
  input logic                      rst_n,
  input sdram_mcb_pkg::mem_req_t   mem_req,
  input sdram_mcb_pkg::mem_ack_t   mem_ack,
  input logic                      wr_done,
  input logic                      rd_done,
  input logic                      wr_rdy,
  input logic                      rd_fifo_empty,
  input sdram_mcb_pkg::stage_cnt_t rd_fifo_cnt,
  input sdram_mcb_pkg::stage_cnt_t wr_fifo_count,
  input sdram_mcb_pkg::xfer_stat_t wr_stat,
  input sdram_mcb_pkg::xfer_stat_t rd_stat,
  input sdram_mcb_pkg::len_t       wr_len_left, // tracker words still to move
  input sdram_mcb_pkg::len_t       rd_len_left
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROW      = `SDRAM_MCB_ROW_WORDS;
  localparam int AF_LIMIT = `SDRAM_MCB_FIFO_DEPTH - `SDRAM_MCB_AF_MARGIN; // 1008 words

  int fail_cnt = 0; // read by the testbench at the end

  // stage stays inside its row and takes the smaller of row room and words left
  function automatic bit stage_ok(input sdram_mcb_pkg::mem_req_t req,
                                  input sdram_mcb_pkg::len_t left);
    int col;
    int room;
    int want;
    col  = int'(req.addr[`SDRAM_MCB_COL_W-1:0]);
    room = ROW - col;
    want = (int'(left) < room) ? int'(left) : room;
    return (col + int'(req.len) <= ROW) && (int'(req.len) == want);
  endfunction

  a_wr_stage: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      $rose(mem_req.wr_req) |-> stage_ok(mem_req, wr_len_left))
    else begin
      $error("write stage length breaks the row rule");
      fail_cnt++;
    end

  a_rd_stage: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      $rose(mem_req.rd_req) |-> stage_ok(mem_req, rd_len_left))
    else begin
      $error("read stage length breaks the row rule");
      fail_cnt++;
    end

  a_wr_req_drop: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      mem_req.wr_req && mem_ack.wr_ack |=> !mem_req.wr_req) // first ack ends the level
    else begin
      $error("write request still high after its first ack");
      fail_cnt++;
    end

  a_rd_req_drop: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      mem_req.rd_req && mem_ack.rd_ack |=> !mem_req.rd_req)
    else begin
      $error("read request still high after its first ack");
      fail_cnt++;
    end

  a_req_excl: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      !(mem_req.wr_req && mem_req.rd_req))
    else begin
      $error("write and read requests high together");
      fail_cnt++;
    end

  a_wr_done_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      wr_done |-> !wr_stat.pending ##1 !wr_done) // pending clears with done
    else begin
      $error("wr_done longer than one cycle or transfer still pending");
      fail_cnt++;
    end

  a_rd_done_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      rd_done |-> !rd_stat.pending ##1 !rd_done)
    else begin
      $error("rd_done longer than one cycle or transfer still pending");
      fail_cnt++;
    end

  a_rd_fifo_bound: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      int'(rd_fifo_cnt) < `SDRAM_MCB_FIFO_DEPTH - 1) // room check keeps a read stage below
    else begin
      $error("read fifo fill reached depth minus one");
      fail_cnt++;
    end

  a_wr_rdy: assert property (@(posedge clk_sdram) disable iff (!rst_n)
      wr_rdy == (int'(wr_fifo_count) <= AF_LIMIT)) // low only past 1008
    else begin
      $error("wr_rdy does not follow the write fifo fill");
      fail_cnt++;
    end

  a_reset_vals: assert property (@(posedge clk_sdram)
      $rose(rst_n) |-> !mem_req.wr_req && !mem_req.rd_req && !wr_done && !rd_done
                       && rd_fifo_empty && wr_rdy && !wr_stat.pending && !rd_stat.pending)
    else begin
      $error("outputs not at their reset values when reset ends");
      fail_cnt++;
    end

endmodule

bind sdram_mcb_top sdram_mcb_tb_assertions u_assertions (
  .clk_sdram    (clk_sdram),
  .rst_n        (rst_n),
  .mem_req      (mem_req),
  .mem_ack      (mem_ack),
  .wr_done      (wr_done),
  .rd_done      (rd_done),
  .wr_rdy       (wr_rdy),
  .rd_fifo_empty(rd_fifo_empty),
  .rd_fifo_cnt  (rd_fifo_cnt),
  .wr_fifo_count(wr_fifo_count),
  .wr_stat      (wr_stat),
  .rd_stat      (rd_stat),
  .wr_len_left  (u_wr_xfer.len_r),
  .rd_len_left  (u_rd_xfer.len_r)
);

/* sdram_mcb_tb.sv */
`include "sdram_mcb_defines.svh"

module sdram_mcb_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam sdram_mcb_pkg::addr_t ADDR_A = {2'd1, 13'd5, 9'd400}; // col 400, spans 3 rows
  localparam sdram_mcb_pkg::addr_t ADDR_B = {2'd2, 13'd100, 9'd0};
  localparam int LEN_A       = 700;
  localparam int LEN_B       = 1400; // outruns the memory, wr_rdy drops
  localparam int LEN_C       = 300;
  localparam int TOTAL_WORDS = 2 * LEN_A + LEN_B + LEN_C;
  localparam int WATCHDOG_NS = 20 * TOTAL_WORDS * 20 + 2000;

  logic                      clk_sdram;
  logic                      rst_n;
  logic                      wr_load;
  sdram_mcb_pkg::addr_t      wr_addr;
  sdram_mcb_pkg::len_t       wr_length;
  logic                      wr_req;
  sdram_mcb_pkg::word_t      din;
  logic                      wr_rdy;
  logic                      wr_done;
  logic                      rd_load;
  sdram_mcb_pkg::addr_t      rd_addr;
  sdram_mcb_pkg::len_t       rd_length;
  logic                      rd_req;
  sdram_mcb_pkg::word_t      dout;
  sdram_mcb_pkg::stage_cnt_t rd_fifo_cnt;
  logic                      rd_fifo_empty;
  logic                      rd_done;
  sdram_mcb_pkg::mem_req_t   mem_req;
  sdram_mcb_pkg::mem_ack_t   mem_ack;
  sdram_mcb_pkg::word_t      mem_wdata;

  sdram_mcb_pkg::word_t exp_data [sdram_mcb_pkg::addr_t]; // words pushed, by address
  sdram_mcb_pkg::word_t mem_model [sdram_mcb_pkg::addr_t]; // sdram contents
  int value_errs  = 0;
  int wr_ack_cnt  = 0;
  int rd_ack_cnt  = 0;
  int wr_done_cnt = 0;
  int rd_done_cnt = 0;
  int rd_fill_exp = 0; // read fifo fill from acks and pops

  sdram_mcb_top i_sdram_mcb_top (.*);

  initial begin
    clk_sdram = 1'b0;
    forever #10 clk_sdram = ~clk_sdram; // 20 ns
  end

  // rd_ack pushes unless full, rd_req pops unless empty
  always @(posedge clk_sdram) begin
    if (rst_n) begin
      rd_fill_exp <= rd_fill_exp
                     + ((mem_ack.rd_ack && rd_fill_exp != `SDRAM_MCB_FIFO_DEPTH - 1) ? 1 : 0)
                     - ((rd_req && rd_fill_exp != 0) ? 1 : 0);
    end
  end

  always @(negedge clk_sdram) begin
    if (wr_done) wr_done_cnt++;
    if (rd_done) rd_done_cnt++;
    check_eq("rd_fifo_cnt", rd_fill_exp, rd_fifo_cnt);
  end

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      value_errs++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // word taken at the edge after wr_ack, head is stable now
  task automatic serve_write(input sdram_mcb_pkg::addr_t base, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      repeat ($urandom % 4) begin
        mem_ack.wr_ack = 1'b0; // stall
        @(negedge clk_sdram);
      end
      mem_ack.wr_ack = 1'b1;
      mem_model[sdram_mcb_pkg::addr_t'(base + i)] = mem_wdata;
      wr_ack_cnt++;
      @(negedge clk_sdram);
    end
    mem_ack.wr_ack = 1'b0;
  endtask

  task automatic serve_read(input sdram_mcb_pkg::addr_t base, input int n);
    int i;
    sdram_mcb_pkg::addr_t a;
    for (i = 0; i < n; i++) begin
      a = sdram_mcb_pkg::addr_t'(base + i);
      repeat ($urandom % 4) begin
        mem_ack.rd_ack = 1'b0;
        @(negedge clk_sdram);
      end
      mem_ack.rd_ack  = 1'b1;
      mem_ack.rd_data = mem_model.exists(a) ? mem_model[a] : '0;
      rd_ack_cnt++;
      @(negedge clk_sdram);
    end
    mem_ack.rd_ack = 1'b0;
  endtask

  // memory model, one stage at a time
  initial begin
    mem_ack = '0;
    forever begin
      @(negedge clk_sdram);
      if (mem_req.wr_req) serve_write(mem_req.addr, int'(mem_req.len));
      else if (mem_req.rd_req) serve_read(mem_req.addr, int'(mem_req.len));
    end
  end

  task automatic push_words(input sdram_mcb_pkg::addr_t base, input int n);
    int i;
    sdram_mcb_pkg::word_t w;
    i = 0;
    while (i < n) begin
      @(negedge clk_sdram);
      wr_req = 1'b0;
      if (wr_rdy) begin
        w = sdram_mcb_pkg::word_t'($urandom);
        din = w;
        wr_req = 1'b1;
        exp_data[sdram_mcb_pkg::addr_t'(base + i)] = w;
        i++;
      end
    end
    @(negedge clk_sdram);
    wr_req = 1'b0;
  endtask

  // pops at random, head compared before it leaves
  task automatic drain_words(input string name, input sdram_mcb_pkg::addr_t base, input int n);
    int i;
    i = 0;
    while (i < n) begin
      @(negedge clk_sdram);
      rd_req = 1'b0;
      if (!rd_fifo_empty && ($urandom % 2 == 0)) begin
        check_eq(name, exp_data[sdram_mcb_pkg::addr_t'(base + i)], dout);
        rd_req = 1'b1;
        i++;
      end
    end
    @(negedge clk_sdram);
    rd_req = 1'b0;
  endtask

  task automatic run_write(input string name, input sdram_mcb_pkg::addr_t base, input int n);
    int ack_base;
    int done_base;
    ack_base  = wr_ack_cnt;
    done_base = wr_done_cnt;
    fork
      begin
        @(negedge clk_sdram);
        wr_addr   = base;
        wr_length = sdram_mcb_pkg::len_t'(n);
        wr_load   = 1'b1;
        repeat (2) @(negedge clk_sdram);
        wr_load   = 1'b0;
      end
      push_words(base, n);
    join
    wait (wr_done_cnt == done_base + 1);
    check_eq({name, " acks"}, n, wr_ack_cnt - ack_base);
  endtask

  task automatic run_read(input string name, input sdram_mcb_pkg::addr_t base, input int n);
    int ack_base;
    int done_base;
    ack_base  = rd_ack_cnt;
    done_base = rd_done_cnt;
    fork
      begin
        @(negedge clk_sdram);
        rd_addr   = base;
        rd_length = sdram_mcb_pkg::len_t'(n);
        rd_load   = 1'b1;
        repeat (2) @(negedge clk_sdram);
        rd_load   = 1'b0;
      end
      drain_words(name, base, n);
    join
    wait (rd_done_cnt == done_base + 1);
    check_eq({name, " acks"}, n, rd_ack_cnt - ack_base);
  endtask

  initial begin
    int i;
    void'($urandom(74));
    rst_n     = 1'b0;
    wr_load   = 1'b0;
    wr_addr   = '0;
    wr_length = '0;
    wr_req    = 1'b0;
    din       = '0;
    rd_load   = 1'b0;
    rd_addr   = '0;
    rd_length = '0;
    rd_req    = 1'b0;
    repeat (16) @(negedge clk_sdram);
    rst_n = 1'b1;
    repeat (4) @(negedge clk_sdram);
    run_write("write_row_cross", ADDR_A, LEN_A); // stages 112, 512, 76
    run_read("read_back", ADDR_A, LEN_A);
    fork
      run_write("overlap_write", ADDR_B, LEN_B);
      run_read("overlap_read", sdram_mcb_pkg::addr_t'(ADDR_A + 100), LEN_C);
    join
    for (i = 0; i < LEN_B; i++) begin
      check_eq("overlap_write_mem", exp_data[sdram_mcb_pkg::addr_t'(ADDR_B + i)],
               mem_model[sdram_mcb_pkg::addr_t'(ADDR_B + i)]);
    end
    repeat (8) @(negedge clk_sdram); // late done pulses would show here
    check_eq("wr_done_pulses", 2, wr_done_cnt);
    check_eq("rd_done_pulses", 2, rd_done_cnt);
    $display("errors: value=%0d assertion=%0d", value_errs,
             i_sdram_mcb_top.u_assertions.fail_cnt);
    if (value_errs == 0 && i_sdram_mcb_top.u_assertions.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, a transfer never completed");
    $display("errors: value=%0d assertion=%0d", value_errs,
             i_sdram_mcb_top.u_assertions.fail_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
sdram_mcb_pkg.sv
sdram_mcb_fifo.sv
sdram_mcb_xfer.sv
sdram_mcb_sched.sv
sdram_mcb_top.sv
sdram_mcb_tb_assertions.sv
sdram_mcb_tb.sv

/* Bender.yml */
package:
  name: sdram_mcb

sources:
  - include_dirs:
      - .
    files:
      - sdram_mcb_pkg.sv
      - sdram_mcb_fifo.sv
      - sdram_mcb_xfer.sv
      - sdram_mcb_sched.sv
      - sdram_mcb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - sdram_mcb_tb_assertions.sv
      - sdram_mcb_tb.sv
